// File: verilog/dcache_pkg.sv
package dcache_pkg;

    // request side types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;

    // one way select bit for a 2-way cache
    typedef logic way_t;

    // one lru bit per set only covers two ways
    localparam int WAYS = 2;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_BITS = $clog2(BYTES_PER_WORD);
    localparam int ADDR_BITS = $bits(addr_t);

    // miss sequencing of the controller
    typedef enum logic [2:0] {
        IDLE,
        EVICT_READ,
        WRITEBACK,
        FETCH,
        REPLAY
    } ctrl_state_t;

endpackage

// File: verilog/data_port_if.sv
interface data_port_if
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 8
) ();

    // word address is way, index, offset
    localparam int ADDR_W = $clog2(WAYS) + $clog2(NUM_SETS) + $clog2(WORDS_PER_LINE);

    logic              en;
    logic [ADDR_W-1:0] addr;
    strobe_t           strobe;
    word_t             wdata;
    word_t             rdata;

    modport ctrl (
        output en, addr, strobe, wdata,
        input  rdata
    );

    modport store (
        input  en, addr, strobe, wdata,
        output rdata
    );

endinterface

// File: verilog/tag_port_if.sv
interface tag_port_if
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 8
) ();

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_BITS - IDX_W - $clog2(WORDS_PER_LINE) - BYTE_BITS;

    logic [IDX_W-1:0] lookup_index;
    logic [TAG_W-1:0] lookup_tag;
    logic             touch;
    way_t             touch_way;
    logic             mark_dirty;
    logic             fill;
    logic             fill_dirty;

    // combinational lookup results
    logic             hit;
    way_t             hit_way;
    way_t             victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;

    modport ctrl (
        output lookup_index, lookup_tag, touch, touch_way, mark_dirty, fill, fill_dirty,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport store (
        input  lookup_index, lookup_tag, touch, touch_way, mark_dirty, fill, fill_dirty,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

endinterface

// File: verilog/tag_store.sv
module tag_store
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 8
) (
    input  logic     clk,
    input  logic     resetn,
    tag_port_if.store tags
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_BITS - IDX_W - $clog2(WORDS_PER_LINE) - BYTE_BITS;

    logic [NUM_SETS-1:0][WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][WAYS-1:0] dirty_q;
    logic [NUM_SETS-1:0]           lru_q;
    logic [TAG_W-1:0]              tag_q [NUM_SETS][WAYS];

    logic [WAYS-1:0] way_hit;
    way_t            victim;

    // compare against both ways of the set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[tags.lookup_index][w]
                       && (tag_q[tags.lookup_index][w] == tags.lookup_tag);
        end
    end

    assign victim            = lru_q[tags.lookup_index];
    assign tags.hit          = |way_hit;
    assign tags.hit_way      = way_hit[1];
    assign tags.victim_way   = victim;
    assign tags.victim_dirty = valid_q[tags.lookup_index][victim]
                             && dirty_q[tags.lookup_index][victim];
    assign tags.victim_tag   = tag_q[tags.lookup_index][victim];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            // lru points away from the last used way
            if (tags.touch) begin
                lru_q[tags.lookup_index] <= ~tags.touch_way;
            end
            if (tags.mark_dirty) begin
                dirty_q[tags.lookup_index][tags.touch_way] <= 1'b1;
            end
            if (tags.fill) begin
                valid_q[tags.lookup_index][victim] <= 1'b1;
                dirty_q[tags.lookup_index][victim] <= tags.fill_dirty;
                lru_q[tags.lookup_index]           <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tags.fill) begin
            tag_q[tags.lookup_index][victim] <= tags.lookup_tag;
        end
    end

    // refill and store-hit dirty marking come from different controller states
    a_fill_excl_dirty: assert property (
        @(posedge clk) disable iff (resetn)
        !(tags.fill && tags.mark_dirty)
    );

endmodule

// File: verilog/data_store.sv
module data_store
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 8
) (
    input  logic      clk,
    data_port_if.store mem
);

    localparam int DEPTH = WAYS * NUM_SETS * WORDS_PER_LINE;

    word_t mem_q [DEPTH];

    // read returns the old word on a write
    always_ff @(posedge clk) begin
        if (mem.en) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (mem.strobe[b]) begin
                    mem_q[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
                end
            end
            mem.rdata <= mem_q[mem.addr];
        end
    end

    a_addr_known: assert property (
        @(posedge clk) mem.en |-> !$isunknown(mem.addr)
    );

endmodule

// File: verilog/evict_buffer.sv
module evict_buffer
    import dcache_pkg::*;
#(
    parameter int WORDS_PER_LINE = 8
) (
    input  logic                              clk,
    input  logic                              load,
    input  logic [$clog2(WORDS_PER_LINE)-1:0] load_offset,
    input  word_t                             load_data,
    input  logic [$clog2(WORDS_PER_LINE)-1:0] beat,
    output word_t                             beat_data
);

    // one victim line filled word by word
    word_t line_q [WORDS_PER_LINE];

    always_ff @(posedge clk) begin
        if (load) begin
            line_q[load_offset] <= load_data;
        end
    end

    // the last word lands in the first writeback cycle and goes out much later
    assign beat_data = line_q[beat];

endmodule

// File: verilog/dcache_ctrl.sv
module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 8
) (
    input  logic    clk,
    input  logic    resetn,

    input  logic    req_valid,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,

    output logic    mem_valid,
    output logic    mem_is_write,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    input  logic    mem_ready,
    input  word_t   mem_rdata,
    input  logic    mem_last,

    data_port_if.ctrl data,
    tag_port_if.ctrl  tags,

    output logic                              evict_load,
    output logic [$clog2(WORDS_PER_LINE)-1:0] evict_offset,
    output word_t                             evict_wdata,
    output logic [$clog2(WORDS_PER_LINE)-1:0] evict_beat,
    input  word_t                             evict_rdata
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int OFF_W = $clog2(WORDS_PER_LINE);
    localparam int TAG_W = ADDR_BITS - IDX_W - OFF_W - BYTE_BITS;
    localparam logic [OFF_W-1:0] LAST_BEAT = OFF_W'(WORDS_PER_LINE - 1);

    ctrl_state_t      state;
    logic [OFF_W-1:0] beat;

    logic             stage_valid;
    addr_t            stage_addr;
    strobe_t          stage_strobe;
    word_t            stage_wdata;

    way_t             vic_way;
    logic [TAG_W-1:0] vic_tag;

    logic [IDX_W-1:0] stage_idx;
    logic [OFF_W-1:0] stage_off;
    logic [TAG_W-1:0] stage_tag;
    logic             miss;
    logic             access;
    logic             fill_beat;

    assign stage_off = stage_addr[BYTE_BITS +: OFF_W];
    assign stage_idx = stage_addr[BYTE_BITS + OFF_W +: IDX_W];
    assign stage_tag = stage_addr[ADDR_BITS-1 -: TAG_W];

    assign miss      = (state == IDLE) && stage_valid && !tags.hit;
    assign access    = ((state == IDLE) && stage_valid && tags.hit) || (state == REPLAY);
    assign fill_beat = (state == FETCH) && mem_ready;
    assign addr_ok   = ((state == IDLE) && !miss) || (state == REPLAY);

    // request stage
    always_ff @(posedge clk) begin
        if (resetn) begin
            stage_valid <= 1'b0;
        end else if (addr_ok) begin
            stage_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok && req_valid) begin
            stage_addr   <= req_addr;
            stage_strobe <= req_strobe;
            stage_wdata  <= req_wdata;
        end
        if (miss) begin
            vic_way <= tags.victim_way;
            vic_tag <= tags.victim_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        state <= tags.victim_dirty ? EVICT_READ : FETCH;
                        beat  <= '0;
                    end
                end
                EVICT_READ: begin
                    beat <= beat + 1'b1;
                    if (beat == LAST_BEAT) begin
                        state <= WRITEBACK;
                        beat  <= '0;
                    end
                end
                // fetch burst follows the writeback with no idle cycle
                WRITEBACK: begin
                    if (mem_ready) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= FETCH;
                            beat  <= '0;
                        end
                    end
                end
                FETCH: begin
                    if (mem_ready) begin
                        beat <= beat + 1'b1;
                        if (mem_last) begin
                            state <= REPLAY;
                            beat  <= '0;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok    <= 1'b0;
            evict_load <= 1'b0;
        end else begin
            data_ok    <= access;
            evict_load <= (state == EVICT_READ);
        end
    end

    always_ff @(posedge clk) begin
        evict_offset <= beat;
    end

    // data store is shared by hits, eviction reads and refill writes
    assign data.en     = access || (state == EVICT_READ) || fill_beat;
    assign data.addr   = access ? {tags.hit_way, stage_idx, stage_off} : {vic_way, stage_idx, beat};
    assign data.strobe = access ? stage_strobe : (fill_beat ? '1 : '0);
    assign data.wdata  = (state == FETCH) ? mem_rdata : stage_wdata;
    assign rdata       = data.rdata;

    assign tags.lookup_index = stage_idx;
    assign tags.lookup_tag   = stage_tag;
    assign tags.touch        = access;
    assign tags.touch_way    = tags.hit_way;
    assign tags.mark_dirty   = access && (|stage_strobe);
    assign tags.fill         = fill_beat && mem_last;
    assign tags.fill_dirty   = |stage_strobe;

    assign evict_wdata = data.rdata;
    assign evict_beat  = beat;

    assign mem_valid    = (state == WRITEBACK) || (state == FETCH);
    assign mem_is_write = (state == WRITEBACK);
    assign mem_addr     = {(state == WRITEBACK) ? vic_tag : stage_tag, stage_idx,
                           {(OFF_W + BYTE_BITS){1'b0}}};
    assign mem_wdata    = evict_rdata;

    a_no_ok_in_burst: assert property (
        @(posedge clk) disable iff (resetn)
        !(data_ok && mem_valid)
    );

    a_burst_held: assert property (
        @(posedge clk) disable iff (resetn)
        mem_valid && !(mem_ready && mem_last) |=> mem_valid
    );

endmodule

// File: verilog/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int WORDS_PER_LINE = 8
) (
    input  logic    clk,
    input  logic    resetn,

    input  logic    req_valid,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,

    output logic    mem_valid,
    output logic    mem_is_write,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    input  logic    mem_ready,
    input  word_t   mem_rdata,
    input  logic    mem_last
);

    localparam int OFF_W = $clog2(WORDS_PER_LINE);

    data_port_if #(.NUM_SETS(NUM_SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) data_bus ();
    tag_port_if  #(.NUM_SETS(NUM_SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) tag_bus ();

    // victim line path
    logic             evict_load;
    logic [OFF_W-1:0] evict_offset;
    word_t            evict_wdata;
    logic [OFF_W-1:0] evict_beat;
    word_t            evict_rdata;

    dcache_ctrl #(.NUM_SETS(NUM_SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) u_ctrl (
        .clk, .resetn,
        .req_valid, .req_addr, .req_strobe, .req_wdata,
        .addr_ok, .data_ok, .rdata,
        .mem_valid, .mem_is_write, .mem_addr, .mem_wdata,
        .mem_ready, .mem_rdata, .mem_last,
        .data (data_bus.ctrl),
        .tags (tag_bus.ctrl),
        .evict_load, .evict_offset, .evict_wdata, .evict_beat, .evict_rdata
    );

    tag_store #(.NUM_SETS(NUM_SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) u_tag_store (
        .clk, .resetn,
        .tags (tag_bus.store)
    );

    data_store #(.NUM_SETS(NUM_SETS), .WORDS_PER_LINE(WORDS_PER_LINE)) u_data_store (
        .clk,
        .mem (data_bus.store)
    );

    evict_buffer #(.WORDS_PER_LINE(WORDS_PER_LINE)) u_evict_buffer (
        .clk,
        .load        (evict_load),
        .load_offset (evict_offset),
        .load_data   (evict_wdata),
        .beat        (evict_beat),
        .beat_data   (evict_rdata)
    );

endmodule

// File: tb/dcache_tb.sv
module dcache_tb
    import dcache_pkg::*;
();

    localparam int WORDS_PER_LINE = 8;
    localparam int OFF_W = $clog2(WORDS_PER_LINE);
    localparam logic [OFF_W-1:0] LAST_BEAT = OFF_W'(WORDS_PER_LINE - 1);
    localparam int MEM_WORDS = 4096;
    // 300 operations at 40 cycles each plus a margin
    localparam int CYCLE_LIMIT = 15000;
    localparam int RANDOM_OPS = 300;

    typedef struct packed {
        logic  is_load;
        word_t data;
    } pending_t;

    logic    clk;
    logic    resetn;
    logic    req_valid;
    addr_t   req_addr;
    strobe_t req_strobe;
    word_t   req_wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    mem_valid;
    logic    mem_is_write;
    addr_t   mem_addr;
    word_t   mem_wdata;
    logic    mem_ready;
    word_t   mem_rdata;
    logic    mem_last;

    // 16 KB backing memory and the byte image it is checked against
    word_t            mem_words [MEM_WORDS];
    logic [7:0]       ref_bytes [4*MEM_WORDS];
    logic [OFF_W-1:0] burst_beat;
    logic             wait_left;
    word_t            wait_draw;

    pending_t pending [$];
    pending_t entry;
    integer   seed;
    int       errors;
    int       accepted;
    int       responses;
    int       read_bursts;
    int       write_bursts;
    int       cycles;

    dcache_top u_dcache_top (
        .clk, .resetn,
        .req_valid, .req_addr, .req_strobe, .req_wdata,
        .addr_ok, .data_ok, .rdata,
        .mem_valid, .mem_is_write, .mem_addr, .mem_wdata,
        .mem_ready, .mem_rdata, .mem_last
    );

    always #50 clk = ~clk;

    // hash of the byte address
    function automatic word_t init_word(input addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic word_t expected_word(input addr_t a);
        logic [13:0] base;
        base = {a[13:2], 2'b00};
        return {ref_bytes[base + 14'd3], ref_bytes[base + 14'd2],
                ref_bytes[base + 14'd1], ref_bytes[base]};
    endfunction

    task automatic merge_store(input addr_t a, input strobe_t s, input word_t d);
        logic [13:0] base;
        base = {a[13:2], 2'b00};
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (s[b]) begin
                ref_bytes[base + 14'(b)] = d[8*b +: 8];
            end
        end
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic end_run();
        $display("errors %0d, requests %0d, responses %0d", errors, accepted, responses);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // memory answers shortly after each edge
    always @(posedge clk) begin
        #10;
        mem_ready = 1'b0;
        mem_last  = 1'b0;
        if (!resetn && mem_valid) begin
            if (wait_left) begin
                wait_left = 1'b0;
            end else begin
                mem_ready = 1'b1;
                mem_last  = (burst_beat == LAST_BEAT);
                mem_rdata = mem_words[{mem_addr[13:OFF_W+2], burst_beat}];
            end
        end
    end

    // a beat completes at the coming edge
    always @(negedge clk) begin
        if (!resetn && mem_valid && mem_ready) begin
            // line aligned and inside the 16 KB test range
            check_value(mem_addr & 32'hffff_c01f, 32'd0, "burst address outside its line");
            if (mem_is_write) begin
                check_value(mem_wdata,
                            expected_word({18'd0, mem_addr[13:OFF_W+2], burst_beat, 2'b00}),
                            "writeback word");
                mem_words[{mem_addr[13:OFF_W+2], burst_beat}] = mem_wdata;
            end
            if (mem_last && mem_is_write) begin
                write_bursts++;
            end else if (mem_last) begin
                read_bursts++;
            end
            burst_beat = burst_beat + 1'b1;
            wait_draw  = $random(seed);
            wait_left  = wait_draw[0];
        end
    end

    // responses before the request taken at the coming edge
    always @(negedge clk) begin
        if (!resetn) begin
            if (data_ok) begin
                responses++;
                if (pending.size() == 0) begin
                    errors++;
                    $display("data_ok at %0t with no request outstanding", $time);
                end else begin
                    entry = pending.pop_front();
                    if (entry.is_load) begin
                        check_value(rdata, entry.data, "load data");
                    end
                end
            end
            if (req_valid && addr_ok) begin
                accepted++;
                entry.is_load = (req_strobe == 4'h0);
                entry.data    = expected_word(req_addr);
                merge_store(req_addr, req_strobe, req_wdata);
                pending.push_back(entry);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            end_run();
        end
    end

    // holds the request up to the edge that takes it
    task automatic send_request(input addr_t a, input strobe_t s, input word_t d);
        req_valid  = 1'b1;
        req_addr   = a;
        req_strobe = s;
        req_wdata  = d;
        @(negedge clk);
        while (!addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic access_and_count(input addr_t a, input strobe_t s, input word_t d,
                                    input int reads, input int writes, input string what);
        int r0;
        int w0;
        r0 = read_bursts;
        w0 = write_bursts;
        send_request(a, s, d);
        wait_idle();
        check_value(read_bursts - r0, reads, {what, " read bursts"});
        check_value(write_bursts - w0, writes, {what, " write bursts"});
    endtask

    initial begin
        word_t   stim;
        word_t   wdata;
        clk = 1'b0;
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_strobe = '0;
        req_wdata = '0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        mem_last = 1'b0;
        seed = 43;
        burst_beat = '0;
        wait_left = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[12'(i)] = init_word(32'(4 * i));
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                ref_bytes[14'(4 * i + b)] = mem_words[12'(i)][8*b +: 8];
            end
        end
        repeat (2) @(posedge clk);
        #10;
        resetn = 1'b0;

        @(negedge clk);
        check_value(32'(addr_ok), 32'd1, "addr_ok after reset");
        check_value(32'(data_ok), 32'd0, "data_ok after reset");
        check_value(32'(mem_valid), 32'd0, "mem_valid after reset");
        @(posedge clk);
        #10;

        access_and_count(32'h1004, 4'h0, '0, 1, 0, "cold load");
        access_and_count(32'h1018, 4'h0, '0, 0, 0, "warm load");

        // partial stores merge into the hit line
        send_request(32'h1008, 4'b0011, 32'h1122_3344);
        send_request(32'h1008, 4'b1100, 32'h5566_7788);
        send_request(32'h1008, 4'h0, '0);
        send_request(32'h100c, 4'b1000, 32'hdead_beef);
        send_request(32'h100c, 4'b0010, 32'hcafe_f00d);
        send_request(32'h100c, 4'h0, '0);
        wait_idle();

        // dirty lines A B C in set 5
        access_and_count(32'h00a0, 4'hf, 32'ha0a0_a0a0, 1, 0, "store A");
        access_and_count(32'h02a0, 4'b0101, 32'h0b0b_0b0b, 1, 0, "store B");
        access_and_count(32'h00a4, 4'h0, '0, 0, 0, "load A");
        access_and_count(32'h04a8, 4'b1001, 32'h0c0c_0c0c, 1, 1, "store C");
        access_and_count(32'h00ac, 4'h0, '0, 0, 0, "load A after C");
        access_and_count(32'h02b0, 4'h0, '0, 1, 1, "load B over dirty C");
        // clean lines A B C in set 6
        access_and_count(32'h00c0, 4'h0, '0, 1, 0, "clean A");
        access_and_count(32'h02c0, 4'h0, '0, 1, 0, "clean B");
        access_and_count(32'h00c4, 4'h0, '0, 0, 0, "clean A again");
        access_and_count(32'h04c8, 4'h0, '0, 1, 0, "clean C");
        access_and_count(32'h00cc, 4'h0, '0, 0, 0, "clean A after C");
        access_and_count(32'h02d0, 4'h0, '0, 1, 0, "clean B over C");

        // four tags over sets 3 and 4
        for (int n = 0; n < RANDOM_OPS; n++) begin
            stim  = $random(seed);
            wdata = $random(seed);
            send_request({21'd0, stim[3:2], stim[4] ? 4'd4 : 4'd3, stim[7:5], 2'b00},
                         stim[0] ? stim[11:8] : 4'h0, wdata);
        end
        wait_idle();
        check_value(responses, accepted, "data_ok count");
        end_run();
    end

endmodule

// File: dcache.f
verilog/dcache_pkg.sv
verilog/data_port_if.sv
verilog/tag_port_if.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/evict_buffer.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcache_tb -f dcache.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
